/* hdl/exec_defines.svh */
// Width macros for the execute stage; the store lane logic assumes a 32-bit word
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

////////////////////
// Datapath widths
////////////////////

// Data and address width
`define EXEC_XLEN 32

// Flow tag, wraps after eight redirects
`define EXEC_TAG_W 3

// Low bits of the second operand used by shifts
`define EXEC_SHAMT_W 5

// Return address is pc plus one instruction
`define EXEC_LINK_OFFSET 4

`endif

/* hdl/exec_pkg.sv */
// Types for the RV32I execute stage subset; no M, no CSR and only machine-mode ECALL
`include "exec_defines.svh"

package exec_pkg;

    ////////////////////
    // Vectors
    ////////////////////

    typedef logic [`EXEC_XLEN-1:0]  word_t;
    typedef logic [`EXEC_TAG_W-1:0] tag_t;
    typedef logic [3:0]             byte_en_t;

    ////////////////////
    // Encodings
    ////////////////////

    // Decoded operation, as handed over by the decode stage
    typedef enum logic [5:0] {
        NOP, ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL, SRL, SRA, LUI,
        LB, LBU, LH, LHU, LW, SB, SH, SW,
        BEQ, BNE, BLT, BLTU, BGE, BGEU, JAL, JALR,
        ECALL, EBREAK, MRET
    } op_e;

    // Exception cause, values follow the mcause numbering
    typedef enum logic [3:0] {
        MISALIGNED = 4'd0,
        ILLEGAL    = 4'd2,
        BREAKPOINT = 4'd3,
        LOAD_FAULT = 4'd5,
        ECALL_M    = 4'd11,
        NO_EXC     = 4'd15
    } exc_code_e;

    ////////////////////
    // Bundles
    ////////////////////

    typedef struct packed {
        word_t pc;
        word_t first_op;
        word_t second_op;
        word_t third_op;
        op_e   op;
        tag_t  tag;
    } exec_in_t;

    typedef struct packed {
        logic illegal;
        logic misaligned_fetch;
        logic load_fault;
    } exc_flags_t;

    typedef struct packed {
        word_t    address;
        logic     read_en;
        byte_en_t byte_en;
        word_t    write_data;
    } mem_req_t;

    typedef struct packed {
        logic  write_enable;
        op_e   op;
        word_t result;
    } wb_t;

    typedef struct packed {
        logic      raise;
        exc_code_e code;
        logic      mret;
    } trap_t;

endpackage

/* hdl/exec_alu.sv */
// Combinational integer ALU; JAL and JALR results come from the link path, not from here
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_alu
    import exec_pkg::*;
(
    input  exec_in_t in_i,
    output word_t    sum_o,
    output word_t    result_o
);

    logic [`EXEC_SHAMT_W-1:0] shamt;

    word_t sum;
    word_t diff;
    word_t and_res;
    word_t or_res;
    word_t xor_res;
    word_t sll_res;
    word_t srl_res;
    word_t sra_res;
    logic  lt_signed;
    logic  lt_unsigned;

    ////////////////////
    // Arithmetic
    ////////////////////

    assign shamt = in_i.second_op[`EXEC_SHAMT_W-1:0];

    always_comb begin
        sum         = in_i.first_op + in_i.second_op;
        diff        = in_i.first_op - in_i.second_op;
        and_res     = in_i.first_op & in_i.second_op;
        or_res      = in_i.first_op | in_i.second_op;
        xor_res     = in_i.first_op ^ in_i.second_op;
        sll_res     = in_i.first_op << shamt;
        srl_res     = in_i.first_op >> shamt;
        // Arithmetic shift keeps the sign of the first operand
        sra_res     = word_t'($signed(in_i.first_op) >>> shamt);
        lt_signed   = $signed(in_i.first_op) < $signed(in_i.second_op);
        lt_unsigned = in_i.first_op < in_i.second_op;
    end

    // Address adder shared with the LSU and the JALR target
    assign sum_o = sum;

    ////////////////////
    // Result select
    ////////////////////

    always_comb begin
        case (in_i.op)
            SUB:     result_o = diff;
            SLT:     result_o = word_t'(lt_signed);
            SLTU:    result_o = word_t'(lt_unsigned);
            XOR:     result_o = xor_res;
            OR:      result_o = or_res;
            AND:     result_o = and_res;
            SLL:     result_o = sll_res;
            SRL:     result_o = srl_res;
            SRA:     result_o = sra_res;
            // Immediate already shifted by decode
            LUI:     result_o = in_i.second_op;
            default: result_o = sum;
        endcase
    end

endmodule

/* hdl/exec_branch.sv */
// Branch decision is raw here and must still be qualified by the kill in the control block
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_branch
    import exec_pkg::*;
(
    input  exec_in_t in_i,
    input  word_t    sum_i,
    output logic     take_o,
    output word_t    target_o,
    output word_t    link_o
);

    logic equal;
    logic lt_signed;
    logic lt_unsigned;

    ////////////////////
    // Compare
    ////////////////////

    assign equal       = in_i.first_op == in_i.second_op;
    assign lt_signed   = $signed(in_i.first_op) < $signed(in_i.second_op);
    assign lt_unsigned = in_i.first_op < in_i.second_op;

    always_comb begin
        case (in_i.op)
            BEQ:       take_o = equal;
            BNE:       take_o = !equal;
            BLT:       take_o = lt_signed;
            BLTU:      take_o = lt_unsigned;
            BGE:       take_o = !lt_signed;
            BGEU:      take_o = !lt_unsigned;
            JAL, JALR: take_o = 1'b1;
            default:   take_o = 1'b0;
        endcase
    end

    ////////////////////
    // Targets
    ////////////////////

    always_comb begin
        case (in_i.op)
            // JALR clears bit 0 of rs1 plus offset
            JALR:    target_o = {sum_i[`EXEC_XLEN-1:1], 1'b0};
            JAL:     target_o = sum_i;
            default: target_o = in_i.pc + in_i.third_op;
        endcase
    end

    assign link_o = in_i.pc + word_t'(`EXEC_LINK_OFFSET);

endmodule

/* hdl/exec_lsu.sv */
// Load and store request path; requests are not qualified by the kill and show up as they are
`timescale 1ns/1ps

module exec_lsu
    import exec_pkg::*;
(
    input  exec_in_t in_i,
    input  word_t    sum_i,
    output mem_req_t req_o
);

    ////////////////////
    // Address and read
    ////////////////////

    // Memory is word addressed, lanes select the bytes
    assign req_o.address = {sum_i[$bits(word_t)-1:2], 2'b00};
    assign req_o.read_en = in_i.op inside {LB, LBU, LH, LHU, LW};

    ////////////////////
    // Store lanes
    ////////////////////

    always_comb begin
        case (in_i.op)
            SB: begin
                case (sum_i[1:0])
                    2'b11:   req_o.byte_en = 4'b1000;
                    2'b10:   req_o.byte_en = 4'b0100;
                    2'b01:   req_o.byte_en = 4'b0010;
                    default: req_o.byte_en = 4'b0001;
                endcase
            end
            // Halfword goes to the upper or lower pair
            SH:      req_o.byte_en = sum_i[1] ? 4'b1100 : 4'b0011;
            SW:      req_o.byte_en = 4'b1111;
            default: req_o.byte_en = 4'b0000;
        endcase
    end

    // Data is replicated so every lane holds the stored value
    always_comb begin
        case (in_i.op)
            SB:      req_o.write_data = {4{in_i.third_op[7:0]}};
            SH:      req_o.write_data = {2{in_i.third_op[15:0]}};
            default: req_o.write_data = in_i.third_op;
        endcase
    end

endmodule

/* hdl/exec_control.sv */
// Tag, kill and trap control; the tag advances even while the write-back is stalled
`timescale 1ns/1ps

module exec_control
    import exec_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic       stall_i,
    input  exec_in_t   in_i,
    input  exc_flags_t flags_i,
    input  logic       mem_access_i,
    input  word_t      alu_result_i,
    input  word_t      link_i,
    input  logic       take_i,
    output logic       jump_o,
    output logic       killed_o,
    output trap_t      trap_o,
    output wb_t        wb_o
);

    tag_t  curr_tag;
    logic  killed;
    logic  write_enable;
    word_t result;

    ////////////////////
    // Kill and jump
    ////////////////////

    // Instructions fetched before the last redirect carry an old tag
    assign killed   = curr_tag != in_i.tag;
    assign killed_o = killed;
    assign jump_o   = take_i && !killed;

    ////////////////////
    // Trap priority
    ////////////////////

    always_comb begin
        trap_o.raise = 1'b0;
        trap_o.code  = NO_EXC;
        trap_o.mret  = 1'b0;
        if (!killed) begin
            if (flags_i.illegal) begin
                trap_o.raise = 1'b1;
                trap_o.code  = ILLEGAL;
            end
            else if (flags_i.misaligned_fetch) begin
                trap_o.raise = 1'b1;
                trap_o.code  = MISALIGNED;
            end
            else if (in_i.op == ECALL) begin
                trap_o.raise = 1'b1;
                trap_o.code  = ECALL_M;
            end
            else if (in_i.op == EBREAK) begin
                trap_o.raise = 1'b1;
                trap_o.code  = BREAKPOINT;
            end
            // Fault only counts when the instruction touches memory
            else if (flags_i.load_fault && mem_access_i) begin
                trap_o.raise = 1'b1;
                trap_o.code  = LOAD_FAULT;
            end
            else if (in_i.op == MRET) begin
                trap_o.mret = 1'b1;
            end
        end
    end

    ////////////////////
    // Write-back
    ////////////////////

    always_comb begin
        case (in_i.op)
            NOP, SB, SH, SW,
            BEQ, BNE, BLT, BLTU, BGE, BGEU,
            ECALL, EBREAK, MRET: write_enable = 1'b0;
            default:             write_enable = !(killed || trap_o.raise);
        endcase
    end

    assign result = (in_i.op inside {JAL, JALR}) ? link_i : alu_result_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_o.write_enable <= 1'b0;
            wb_o.op           <= NOP;
            wb_o.result       <= '0;
        end
        else if (!stall_i) begin
            wb_o.write_enable <= write_enable;
            wb_o.op           <= in_i.op;
            wb_o.result       <= result;
        end
    end

    ////////////////////
    // Flow tag
    ////////////////////

    // Any redirect opens a new flow
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            curr_tag <= '0;
        end
        else if (jump_o || trap_o.raise || trap_o.mret) begin
            curr_tag <= curr_tag + tag_t'(1);
        end
    end

endmodule

/* hdl/exec_stage.sv */
// Execute stage top; upstream holds its inputs during stall, outputs other than wb_o are combinational
`timescale 1ns/1ps

module exec_stage
    import exec_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic       stall_i,
    input  exec_in_t   in_i,
    input  exc_flags_t flags_i,
    output mem_req_t   mem_o,
    output logic       jump_o,
    output word_t      jump_target_o,
    output logic       killed_o,
    output trap_t      trap_o,
    output wb_t        wb_o
);

    word_t    sum;
    word_t    alu_result;
    word_t    link;
    logic     take;
    logic     mem_access;
    mem_req_t mem_req;

    ////////////////////
    // Datapath
    ////////////////////

    exec_alu i_exec_alu (
        .in_i     (in_i),
        .sum_o    (sum),
        .result_o (alu_result)
    );

    exec_branch i_exec_branch (
        .in_i     (in_i),
        .sum_i    (sum),
        .take_o   (take),
        .target_o (jump_target_o),
        .link_o   (link)
    );

    exec_lsu i_exec_lsu (
        .in_i  (in_i),
        .sum_i (sum),
        .req_o (mem_req)
    );

    assign mem_o = mem_req;

    // Load fault is only honoured for loads and stores
    assign mem_access = mem_req.read_en || (mem_req.byte_en != '0);

    ////////////////////
    // Control
    ////////////////////

    exec_control i_exec_control (
        .clk          (clk),
        .reset_n      (reset_n),
        .stall_i      (stall_i),
        .in_i         (in_i),
        .flags_i      (flags_i),
        .mem_access_i (mem_access),
        .alu_result_i (alu_result),
        .link_i       (link),
        .take_i       (take),
        .jump_o       (jump_o),
        .killed_o     (killed_o),
        .trap_o       (trap_o),
        .wb_o         (wb_o)
    );

endmodule

/* test/exec_stage_checker.sv */
// Bound into every exec_stage instance; properties are only evaluated while reset_n is high
`timescale 1ns/1ps

module exec_stage_checker
    import exec_pkg::*;
(
    input logic  clk,
    input logic  reset_n,
    input logic  stall_i,
    input logic  killed_o,
    input trap_t trap_o,
    input wb_t   wb_o
);

    // Count of failed assertions
    int failures = 0;

    // Return from trap never coincides with a new trap
    assert property (@(posedge clk) disable iff (!reset_n)
        !(trap_o.raise && trap_o.mret))
        else begin
            failures++;
            $error("raise and mret are high together");
        end

    // Killed instructions raise nothing
    assert property (@(posedge clk) disable iff (!reset_n)
        killed_o |-> !trap_o.raise)
        else begin
            failures++;
            $error("killed instruction raised a trap");
        end

    // Nor do they reach the register file
    assert property (@(posedge clk) disable iff (!reset_n)
        (killed_o && !stall_i) |=> !wb_o.write_enable)
        else begin
            failures++;
            $error("killed instruction wrote back");
        end

    assert property (@(posedge clk) disable iff (!reset_n)
        stall_i |=> $stable(wb_o))
        else begin
            failures++;
            $error("wb_o changed during a stalled cycle");
        end

endmodule

bind exec_stage exec_stage_checker i_exec_stage_checker (.*);

/* test/tb_exec_stage.sv */
// Run from the project root so the vector file is found; NUM_TESTS must match its line count
`timescale 1ns/1ps

module tb_exec_stage
    import exec_pkg::*;
();

    localparam int NUM_TESTS      = 38;
    localparam int FIELDS         = 20;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = NUM_TESTS + 40;

    logic       clk;
    logic       reset_n;
    logic       stall;
    exec_in_t   instr;
    exc_flags_t flags;
    mem_req_t   mem;
    logic       jump;
    word_t      jump_target;
    logic       killed;
    trap_t      trap;
    wb_t        wb;

    logic [31:0] vectors [0:NUM_TESTS*FIELDS-1];
    int          cycle_count;
    logic        exp_we;
    op_e         exp_op;
    word_t       exp_result;

    exec_stage i_exec_stage (
        .clk           (clk),
        .reset_n       (reset_n),
        .stall_i       (stall),
        .in_i          (instr),
        .flags_i       (flags),
        .mem_o         (mem),
        .jump_o        (jump),
        .jump_target_o (jump_target),
        .killed_o      (killed),
        .trap_o        (trap),
        .wb_o          (wb)
    );

    ////////////////////
    // Helpers
    ////////////////////

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    task automatic apply_vector(input int idx);
        int base;
        base = idx * FIELDS;
        instr.op        <= op_e'(vectors[base][5:0]);
        instr.pc        <= vectors[base+1];
        instr.first_op  <= vectors[base+2];
        instr.second_op <= vectors[base+3];
        instr.third_op  <= vectors[base+4];
        instr.tag       <= tag_t'(vectors[base+5]);
        flags           <= exc_flags_t'(vectors[base+6][2:0]);
        stall           <= vectors[base+7][0];
    endtask

    // Combinational outputs of the instruction now on the inputs
    task automatic check_outputs(input int idx);
        int base;
        base = idx * FIELDS;
        compare_value("mem address", mem.address, vectors[base+8]);
        compare_value("mem read_en", mem.read_en, vectors[base+9]);
        compare_value("mem byte_en", mem.byte_en, vectors[base+10]);
        compare_value("mem write_data", mem.write_data, vectors[base+11]);
        compare_value("jump", jump, vectors[base+12]);
        compare_value("jump target", jump_target, vectors[base+13]);
        compare_value("killed", killed, vectors[base+14]);
        compare_value("trap raise", trap.raise, vectors[base+15]);
        compare_value("trap code", trap.code, vectors[base+16]);
        compare_value("trap mret", trap.mret, vectors[base+17]);
    endtask

    task automatic check_writeback();
        compare_value("wb write_enable", wb.write_enable, exp_we);
        compare_value("wb op", wb.op, exp_op);
        compare_value("wb result", wb.result, exp_result);
    endtask

    // Write-back register only loads on unstalled cycles
    task automatic update_expected(input int idx);
        int base;
        base = idx * FIELDS;
        if (!vectors[base+7][0]) begin
            exp_we     = vectors[base+18][0];
            exp_op     = op_e'(vectors[base][5:0]);
            exp_result = vectors[base+19];
        end
    endtask

    ////////////////////
    // Clock and timeout
    ////////////////////

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count > TIMEOUT_CYCLES) begin
                $display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
                $display("Some tests failed");
                $fatal(1, "Timeout");
            end
        end
    end

    // Stop at the first assertion failure of the bound checker
    initial begin
        wait (i_exec_stage.i_exec_stage_checker.failures != 0);
        $display("An assertion in the bound checker failed");
        $display("Some tests failed");
        $fatal(1, "Assertion failure");
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        reset_n     = 1'b0;
        stall       = 1'b0;
        instr       = '0;
        flags       = '0;
        exp_we      = 1'b0;
        exp_op      = NOP;
        exp_result  = '0;
        $readmemh("test/exec_tests.txt", vectors);
        if ($isunknown(vectors[NUM_TESTS*FIELDS-1])) begin
            $display("The test vector file is missing or shorter than expected");
            $display("Some tests failed");
            $fatal(1, "Bad vector file");
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            @(posedge clk);
            apply_vector(i);
            #1;
            // wb_o now holds the result of the last unstalled line
            check_writeback();
            check_outputs(i);
            update_expected(i);
        end
        @(posedge clk);
        #1;
        check_writeback();
        $display("All tests passed");
        $finish;
    end

endmodule

/* test/exec_tests.txt */
// op pc first second third tag flags(illegal,misaligned,load_fault) stall
// then expected: addr read_en byte_en wdata jump target killed raise code mret wb_we wb_result
01 00000100 00000005 00000007 00000000 0 0 0 0000000c 0 0 00000000 0 00000100 0 0 f 0 1 0000000c
02 00000100 00000005 00000007 00000000 0 0 0 0000000c 0 0 00000000 0 00000100 0 0 f 0 1 fffffffe
08 00000100 00000001 00000024 00000000 0 0 0 00000024 0 0 00000000 0 00000100 0 0 f 0 1 00000010
0a 00000100 80000000 00000004 00000000 0 0 0 80000004 0 0 00000000 0 00000100 0 0 f 0 1 f8000000
03 00000100 ffffffff 00000001 00000000 0 0 0 00000000 0 0 00000000 0 00000100 0 0 f 0 1 00000001
04 00000100 ffffffff 00000001 00000000 0 0 0 00000000 0 0 00000000 0 00000100 0 0 f 0 1 00000000
0b 00000100 00000000 12345000 00000000 0 0 0 12345000 0 0 00000000 0 00000100 0 0 f 0 1 12345000
11 00000100 00001000 00000000 aabbccdd 0 0 0 00001000 0 1 dddddddd 0 aabbcddd 0 0 f 0 0 00001000
11 00000100 00001000 00000001 aabbccdd 0 0 0 00001000 0 2 dddddddd 0 aabbcddd 0 0 f 0 0 00001001
11 00000100 00001000 00000002 aabbccdd 0 0 0 00001000 0 4 dddddddd 0 aabbcddd 0 0 f 0 0 00001002
11 00000100 00001000 00000003 aabbccdd 0 0 0 00001000 0 8 dddddddd 0 aabbcddd 0 0 f 0 0 00001003
12 00000100 00001000 00000000 aabbccdd 0 0 0 00001000 0 3 ccddccdd 0 aabbcddd 0 0 f 0 0 00001000
12 00000100 00001000 00000002 aabbccdd 0 0 0 00001000 0 c ccddccdd 0 aabbcddd 0 0 f 0 0 00001002
13 00000100 00001000 00000000 aabbccdd 0 0 0 00001000 0 f aabbccdd 0 aabbcddd 0 0 f 0 0 00001000
10 00000100 00002000 00000006 00000000 0 0 0 00002004 1 0 00000000 0 00000100 0 0 f 0 1 00002006
14 00000100 00000005 00000005 00000040 0 0 0 00000008 0 0 00000040 1 00000140 0 0 f 0 0 0000000a
15 00000100 00000005 00000005 00000040 1 0 0 00000008 0 0 00000040 0 00000140 0 0 f 0 0 0000000a
16 00000100 ffffffff 00000001 00000040 1 0 0 00000000 0 0 00000040 1 00000140 0 0 f 0 0 00000000
17 00000100 ffffffff 00000001 00000040 2 0 0 00000000 0 0 00000040 0 00000140 0 0 f 0 0 00000000
18 00000100 ffffffff 00000001 00000040 2 0 0 00000000 0 0 00000040 0 00000140 0 0 f 0 0 00000000
19 00000100 ffffffff 00000001 00000040 2 0 0 00000000 0 0 00000040 1 00000140 0 0 f 0 0 00000000
1a 00000200 00000200 00000010 00000000 3 0 0 00000210 0 0 00000000 1 00000210 0 0 f 0 1 00000204
1b 00000300 00001003 00000000 00000000 4 0 0 00001000 0 0 00000000 1 00001002 0 0 f 0 1 00000304
01 00000100 00000001 00000002 00000000 4 0 0 00000000 0 0 00000000 0 00000100 1 0 f 0 0 00000003
14 00000100 00000001 00000001 00000040 4 0 0 00000000 0 0 00000040 0 00000140 1 0 f 0 0 00000002
1c 00000100 00000000 00000000 00000000 4 0 0 00000000 0 0 00000000 0 00000100 1 0 f 0 0 00000000
01 00000100 00000001 00000002 00000000 5 0 0 00000000 0 0 00000000 0 00000100 0 0 f 0 1 00000003
01 00000100 00000001 00000002 00000000 5 7 0 00000000 0 0 00000000 0 00000100 0 1 2 0 0 00000003
1c 00000100 00000000 00000000 00000000 6 2 0 00000000 0 0 00000000 0 00000100 0 1 0 0 0 00000000
1c 00000100 00000000 00000000 00000000 7 0 0 00000000 0 0 00000000 0 00000100 0 1 b 0 0 00000000
1d 00000100 00000000 00000000 00000000 0 0 0 00000000 0 0 00000000 0 00000100 0 1 3 0 0 00000000
01 00000100 00000001 00000002 00000000 1 1 0 00000000 0 0 00000000 0 00000100 0 0 f 0 1 00000003
10 00000100 00002000 00000004 00000000 1 1 0 00002004 1 0 00000000 0 00000100 0 1 5 0 0 00002004
1e 00000100 00000000 00000000 00000000 2 0 0 00000000 0 0 00000000 0 00000100 0 0 f 1 0 00000000
01 00000100 00000010 00000020 00000000 3 0 0 00000030 0 0 00000000 0 00000100 0 0 f 0 1 00000030
02 00000100 00000010 00000020 00000000 3 0 1 00000030 0 0 00000000 0 00000100 0 0 f 0 1 fffffff0
05 00000100 0000000f 00000001 00000000 3 0 1 00000010 0 0 00000000 0 00000100 0 0 f 0 1 0000000e
06 00000100 00000f00 000000f0 00000000 3 0 0 00000ff0 0 0 00000000 0 00000100 0 0 f 0 1 00000ff0

/* vlog.f */
+incdir+hdl
hdl/exec_pkg.sv
hdl/exec_alu.sv
hdl/exec_branch.sv
hdl/exec_lsu.sv
hdl/exec_control.sv
hdl/exec_stage.sv
test/exec_stage_checker.sv
test/tb_exec_stage.sv

/* Bender.yml */
package:
  name: exec_stage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/exec_pkg.sv
      - hdl/exec_alu.sv
      - hdl/exec_branch.sv
      - hdl/exec_lsu.sv
      - hdl/exec_control.sv
      - hdl/exec_stage.sv
  - target: test
    files:
      - test/exec_stage_checker.sv
      - test/tb_exec_stage.sv
